/* design/spi_mem_cfg.svh */
`ifndef SPI_MEM_CFG_SVH
`define SPI_MEM_CFG_SVH

// apb address width
`define SPI_ADDR_W 32

// apb data width, also the widest payload of one transfer
`define SPI_DATA_W 32

// opcode + 24-bit device address + up to four data bytes
`define SPI_FRAME_W 64

// a write here sends pwdata[7:0] as a lone opcode byte
`define SPI_RAW_ADDR 32'h3080_0004

`endif

/* design/spi_mem_pkg.sv */
`include "spi_mem_cfg.svh"

package spi_mem_pkg;

	// first byte on the wire
	// CMD_RAW only tags a raw transfer, its opcode comes from the bus data
	typedef enum logic [7:0] {
		CMD_RAW   = 8'h00,
		CMD_WRITE = 8'h02,
		CMD_READ  = 8'h03
	} spi_cmd_e;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT,
		ST_DONE
	} ctrl_state_e;

	// one transfer as decoded from an apb access
	typedef struct packed {
		spi_cmd_e               cmd;
		logic [7:0]             raw_op;
		logic [23:0]            addr;
		// bus order, byte 0 in the low bits
		logic [`SPI_DATA_W-1:0] wdata;
		// 1, 2 or 4
		logic [2:0]             nbytes;
	} xfer_req_t;

endpackage

/* design/spi_mem_ctrl.sv */
`timescale 1ns/1ps

`include "spi_mem_cfg.svh"

module spi_mem_ctrl
	import spi_mem_pkg::*;
(
	input  logic                     pclk,
	input  logic                     rst_n,
	input  logic [`SPI_ADDR_W-1:0]   paddr,
	input  logic [`SPI_DATA_W-1:0]   pwdata,
	input  logic [`SPI_DATA_W/8-1:0] pstrb,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic                     done,
	input  logic [`SPI_DATA_W-1:0]   rdata,
	output logic                     pready,
	output logic                     pslverr,
	output logic [`SPI_DATA_W-1:0]   prdata,
	output xfer_req_t                req,
	output logic                     load,
	output logic                     start
);

	ctrl_state_e state;
	logic        access;
	logic        strb_ok;
	logic [2:0]  nbytes_dec;
	logic        accept;

	// access phase of an apb transfer
	assign access = psel && penable;
	assign accept = (state == ST_IDLE) && access && strb_ok;

	// only byte, halfword and word strobes map to a transfer size
	always_comb begin
		strb_ok = 1'b1;
		case (pstrb)
			4'b0001: nbytes_dec = 3'd1;
			4'b0011: nbytes_dec = 3'd2;
			4'b1111: nbytes_dec = 3'd4;
			default: begin
				nbytes_dec = 3'd0;
				strb_ok    = 1'b0;
			end
		endcase
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			load    <= 1'b0;
			start   <= 1'b0;
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (access && !strb_ok) begin
						// refuse at once, nothing goes out on the pins
						pready  <= 1'b1;
						pslverr <= 1'b1;
						state   <= ST_DONE;
					end else if (access) begin
						load  <= 1'b1;
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					// frame builder registers on this edge
					load  <= 1'b0;
					start <= 1'b1;
					state <= ST_SHIFT;
				end
				ST_SHIFT: begin
					start <= 1'b0;
					if (done) begin
						pready <= 1'b1;
						state  <= ST_DONE;
					end
				end
				ST_DONE: begin
					// single cycle of pready, master drops penable after it
					pready  <= 1'b0;
					pslverr <= 1'b0;
					state   <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request and read data are payload
	always_ff @(posedge pclk) begin
		if (accept) begin
			if (pwrite && paddr == `SPI_RAW_ADDR)
				req.cmd <= CMD_RAW;
			else if (pwrite)
				req.cmd <= CMD_WRITE;
			else
				req.cmd <= CMD_READ;
			req.raw_op <= pwdata[7:0];
			req.addr   <= paddr[23:0];
			req.wdata  <= pwdata;
			req.nbytes <= nbytes_dec;
		end
		if (state == ST_SHIFT && done)
			prdata <= rdata;
	end

endmodule

/* design/spi_frame_builder.sv */
`timescale 1ns/1ps

`include "spi_mem_cfg.svh"

module spi_frame_builder
	import spi_mem_pkg::*;
(
	input  logic                   pclk,
	input  logic                   rst_n,
	input  logic                   load,
	input  xfer_req_t              req,
	input  logic [`SPI_DATA_W-1:0] rx_raw,
	output logic [`SPI_FRAME_W-1:0] frame,
	output logic [6:0]             frame_len,
	output logic [2:0]             rx_len,
	output logic [`SPI_DATA_W-1:0] rdata
);

	logic [6:0] body_len;

	// opcode and address are 32 bits, then the data bytes
	assign body_len = 7'd32 + {1'b0, req.nbytes, 3'b000};

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			frame_len <= 7'd0;
			rx_len    <= 3'd0;
		end else if (load) begin
			case (req.cmd)
				CMD_RAW: begin
					frame_len <= 7'd8;
					rx_len    <= 3'd0;
				end
				CMD_WRITE: begin
					frame_len <= body_len;
					rx_len    <= 3'd0;
				end
				default: begin
					frame_len <= body_len;
					rx_len    <= req.nbytes;
				end
			endcase
		end
	end

	// left aligned, bytes past frame_len are never shifted out
	always_ff @(posedge pclk) begin
		if (load) begin
			case (req.cmd)
				CMD_RAW:
					frame <= {req.raw_op, 56'b0};
				CMD_WRITE:
					frame <= {CMD_WRITE, req.addr, req.wdata[7:0], req.wdata[15:8],
						req.wdata[23:16], req.wdata[31:24]};
				default:
					frame <= {CMD_READ, req.addr, 32'b0};
			endcase
		end
	end

	// first byte received lands in rdata[7:0]
	always_comb begin
		case (rx_len)
			3'd1: rdata = {24'b0, rx_raw[7:0]};
			3'd2: rdata = {16'b0, rx_raw[7:0], rx_raw[15:8]};
			3'd4: rdata = {rx_raw[7:0], rx_raw[15:8], rx_raw[23:16], rx_raw[31:24]};
			default: rdata = '0;
		endcase
	end

endmodule

/* design/spi_shift_engine.sv */
`timescale 1ns/1ps

`include "spi_mem_cfg.svh"

module spi_shift_engine (
	input  logic                    pclk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic [`SPI_FRAME_W-1:0] frame,
	input  logic [6:0]              frame_len,
	input  logic [2:0]              rx_len,
	input  logic                    miso,
	output logic                    sck,
	output logic                    cs_n,
	output logic                    mosi,
	output logic                    done,
	output logic [`SPI_DATA_W-1:0]  rx_raw
);

	logic [`SPI_FRAME_W-1:0] shreg;
	logic [6:0]              cnt;
	logic [6:0]              rx_first;
	logic                    phase;
	logic                    busy;

	// receive window covers the trailing rx_len bytes
	assign rx_first = frame_len - {1'b0, rx_len, 3'b000};
	assign sck      = phase;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			phase <= 1'b0;
			cs_n  <= 1'b1;
			mosi  <= 1'b0;
			done  <= 1'b0;
			cnt   <= 7'd0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy  <= 1'b1;
				cs_n  <= 1'b0;
				phase <= 1'b0;
				cnt   <= 7'd0;
				mosi  <= frame[`SPI_FRAME_W-1];
			end else if (busy && !phase) begin
				// mosi has been set up through the low half
				phase <= 1'b1;
			end else if (busy) begin
				phase <= 1'b0;
				cnt   <= cnt + 7'd1;
				if (cnt + 7'd1 == frame_len) begin
					busy <= 1'b0;
					cs_n <= 1'b1;
					mosi <= 1'b0;
					done <= 1'b1;
				end else begin
					mosi <= shreg[`SPI_FRAME_W-1];
				end
			end
		end
	end

	// datapath, no reset needed
	always_ff @(posedge pclk) begin
		if (start && !busy) begin
			shreg  <= frame << 1;
			rx_raw <= '0;
		end else if (busy && phase) begin
			shreg <= shreg << 1;
			// device changes miso on the falling edge, so it is stable here
			if (cnt >= rx_first)
				rx_raw <= {rx_raw[`SPI_DATA_W-2:0], miso};
		end
	end

endmodule

/* design/spi_mem_top.sv */
`timescale 1ns/1ps

`include "spi_mem_cfg.svh"

module spi_mem_top
	import spi_mem_pkg::*;
(
	input  logic                     pclk,
	input  logic                     rst_n,
	input  logic [`SPI_ADDR_W-1:0]   paddr,
	input  logic [`SPI_DATA_W-1:0]   pwdata,
	input  logic [`SPI_DATA_W/8-1:0] pstrb,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	output logic [`SPI_DATA_W-1:0]   prdata,
	output logic                     pready,
	output logic                     pslverr,
	output logic                     sck,
	output logic                     cs_n,
	output logic                     mosi,
	input  logic                     miso
);

	xfer_req_t               req;
	logic                    load;
	logic                    start;
	logic                    done;
	logic [`SPI_FRAME_W-1:0] frame;
	logic [6:0]              frame_len;
	logic [2:0]              rx_len;
	logic [`SPI_DATA_W-1:0]  rx_raw;
	logic [`SPI_DATA_W-1:0]  rdata;

	spi_mem_ctrl u_ctrl (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.done    (done),
		.rdata   (rdata),
		.pready  (pready),
		.pslverr (pslverr),
		.prdata  (prdata),
		.req     (req),
		.load    (load),
		.start   (start)
	);

	spi_frame_builder u_frame (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.load      (load),
		.req       (req),
		.rx_raw    (rx_raw),
		.frame     (frame),
		.frame_len (frame_len),
		.rx_len    (rx_len),
		.rdata     (rdata)
	);

	spi_shift_engine u_shift (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.start     (start),
		.frame     (frame),
		.frame_len (frame_len),
		.rx_len    (rx_len),
		.miso      (miso),
		.sck       (sck),
		.cs_n      (cs_n),
		.mosi      (mosi),
		.done      (done),
		.rx_raw    (rx_raw)
	);

endmodule

/* tests/spi_mem_sva.sv */
`timescale 1ns/1ps

module spi_mem_sva (
	input logic pclk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic sck,
	input logic cs_n,
	input logic mosi
);

	// set by any failing property below
	logic failed = 1'b0;

	// pins idle while reset is held and on the first edge after it
	a_reset_idle: assert property (@(posedge pclk)
		!rst_n |=> cs_n && !sck && !pready && !pslverr)
		else begin
			$error("pins not idle around reset");
			failed = 1'b1;
		end

	a_sck_idle: assert property (@(posedge pclk) disable iff (!rst_n) cs_n |-> !sck)
		else begin
			$error("sck high with cs_n inactive");
			failed = 1'b1;
		end

	// device samples on the high phase
	a_mosi_stable: assert property (@(posedge pclk) disable iff (!rst_n) sck |-> $stable(mosi))
		else begin
			$error("mosi changed while sck high");
			failed = 1'b1;
		end

	a_ready_access: assert property (@(posedge pclk) disable iff (!rst_n)
		pready |-> psel && penable)
		else begin
			$error("pready outside an access phase");
			failed = 1'b1;
		end

	a_ready_pulse: assert property (@(posedge pclk) disable iff (!rst_n) pready |=> !pready)
		else begin
			$error("pready held for two cycles");
			failed = 1'b1;
		end

endmodule

/* tests/spi_mem_model.sv */
`timescale 1ns/1ps

module spi_mem_model (
	input  logic sck,
	input  logic cs_n,
	input  logic mosi,
	output logic miso
);

	logic [7:0] mem [0:255];
	logic [7:0] last_op;
	logic [7:0] shift;
	logic [7:0] base;
	logic [7:0] wr_idx;
	logic [7:0] rd_idx;
	int         nbit;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i * 29 + 11);
		miso    = 1'b0;
		last_op = 8'h00;
		shift   = 8'h00;
		base    = 8'h00;
		nbit    = 0;
	end

	// every frame starts with the opcode
	always @(negedge cs_n)
		nbit = 0;

	// mode 0, device samples mosi on the rising edge
	always @(posedge sck) begin
		if (!cs_n) begin
			shift = {shift[6:0], mosi};
			nbit  = nbit + 1;
			if (nbit == 8)
				last_op = shift;
			else if (nbit == 32)
				base = shift;
			else if (nbit > 32 && nbit % 8 == 0 && last_op == 8'h02) begin
				wr_idx      = base + 8'((nbit - 40) / 8);
				mem[wr_idx] = shift;
			end
		end
	end

	// read data moves on the falling edge, ahead of the next rising edge
	always @(negedge sck) begin
		if (!cs_n && last_op == 8'h03 && nbit >= 32) begin
			rd_idx = base + 8'((nbit - 32) / 8);
			miso   = mem[rd_idx][7 - (nbit - 32) % 8];
		end
	end

endmodule

/* tests/spi_mem_tb.sv */
`timescale 1ns/1ps

`include "spi_mem_cfg.svh"

module spi_mem_tb;

	// 36 transfers of at most about 140 cycles each with margin to spare
	localparam int TIMEOUT_CYCLES = 8000;

	logic        pclk;
	logic        rst_n;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [3:0]  pstrb;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        sck;
	logic        cs_n;
	logic        mosi;
	logic        miso;

	logic [7:0]  ref_mem [0:255];
	logic [31:0] rd_val;
	logic        rd_err;
	logic [7:0]  wr_addr;
	int          sck_rises;
	int          cs_falls;
	int          cycles;

	spi_mem_top DUT (.*);

	spi_mem_model u_model (
		.sck  (sck),
		.cs_n (cs_n),
		.mosi (mosi),
		.miso (miso)
	);

	bind spi_mem_top spi_mem_sva u_sva (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pready  (pready),
		.pslverr (pslverr),
		.sck     (sck),
		.cs_n    (cs_n),
		.mosi    (mosi)
	);

	initial pclk = 1'b0;
	always #2 pclk = ~pclk;

	// bits on the wire in the current access
	always @(posedge sck)
		if (!cs_n)
			sck_rises = sck_rises + 1;

	always @(negedge cs_n)
		cs_falls = cs_falls + 1;

	always @(posedge pclk) begin
		cycles = cycles + 1;
		if (DUT.u_sva.failed) begin
			$display("pin protocol assertion failed at %0t", $time);
			fail_stop();
		end else if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_stop();
		end
	end

	// a refused access answers with both flags in the same cycle
	assert property (@(posedge pclk) disable iff (!rst_n) pslverr |-> pready)
		else begin
			$display("ERR %0t pslverr raised without pready", $time);
			fail_stop();
		end

	task automatic fail_stop();
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
			fail_stop();
		end
	endtask

	task automatic check_idle_pins();
		check_val("cs_n", 32'd1, {31'd0, cs_n});
		check_val("sck", 32'd0, {31'd0, sck});
		check_val("pready", 32'd0, {31'd0, pready});
		check_val("pslverr", 32'd0, {31'd0, pslverr});
	endtask

	function automatic int rand_size();
		return 1 << ($urandom % 3);
	endfunction

	function automatic logic [3:0] size_strb(input int n);
		return (n == 1) ? 4'b0001 : (n == 2) ? 4'b0011 : 4'b1111;
	endfunction

	// setup, access, then wait states until pready
	task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(posedge pclk);
		#1;
		sck_rises = 0;
		cs_falls  = 0;
		psel      = 1'b1;
		pwrite    = wr;
		paddr     = addr;
		pwdata    = data;
		pstrb     = strb;
		@(posedge pclk);
		#1;
		penable = 1'b1;
		@(posedge pclk);
		#1;
		while (!pready) begin
			@(posedge pclk);
			#1;
		end
		rd_val = prdata;
		rd_err = pslverr;
		@(posedge pclk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic do_write(input logic [7:0] addr, input int n);
		logic [31:0] data;
		data = $urandom;
		apb_xfer(1'b1, {24'h0, addr}, data, size_strb(n));
		for (int i = 0; i < n; i++)
			ref_mem[8'(addr + i)] = data[8*i +: 8];
		check_val("pslverr", 32'd0, {31'd0, rd_err});
		check_val("sck count", 32'(32 + 8 * n), 32'(sck_rises));
	endtask

	task automatic do_read(input logic [7:0] addr, input int n);
		logic [31:0] exp;
		exp = '0;
		for (int i = 0; i < n; i++)
			exp[8*i +: 8] = ref_mem[8'(addr + i)];
		apb_xfer(1'b0, {24'h0, addr}, 32'h0, size_strb(n));
		check_val("pslverr", 32'd0, {31'd0, rd_err});
		check_val("sck count", 32'(32 + 8 * n), 32'(sck_rises));
		check_val("prdata", exp, rd_val);
	endtask

	task automatic do_raw(input logic [7:0] op);
		apb_xfer(1'b1, `SPI_RAW_ADDR, {24'h0, op}, 4'b0001);
		check_val("pslverr", 32'd0, {31'd0, rd_err});
		check_val("sck count", 32'd8, 32'(sck_rises));
		check_val("model opcode", {24'h0, op}, {24'h0, u_model.last_op});
	endtask

	task automatic do_bad(input logic [3:0] strb);
		apb_xfer(1'b0, 32'h0000_0010, 32'h0, strb);
		check_val("pslverr", 32'd1, {31'd0, rd_err});
		check_val("cs_n falls", 32'd0, 32'(cs_falls));
	endtask

	initial begin
		void'($urandom(61));
		rst_n     = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		pstrb     = '0;
		cycles    = 0;
		sck_rises = 0;
		cs_falls  = 0;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = 8'(i * 29 + 11);
		repeat (5) @(posedge pclk);
		#1;
		check_idle_pins();
		rst_n = 1'b1;
		@(posedge pclk);
		#1;
		check_idle_pins();
		// read back from the address just written with its own random size
		for (int k = 0; k < 16; k++) begin
			wr_addr = 8'($urandom);
			do_write(wr_addr, rand_size());
			do_read(wr_addr, rand_size());
		end
		// write enable followed by a random opcode
		do_raw(8'h06);
		do_raw(8'($urandom));
		do_bad(4'b0101);
		do_bad(4'b0111);
		if (DUT.u_sva.failed) begin
			$display("pin protocol assertion failed");
			fail_stop();
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

/* src.f */
+incdir+design
design/spi_mem_pkg.sv
design/spi_mem_ctrl.sv
design/spi_frame_builder.sv
design/spi_shift_engine.sv
design/spi_mem_top.sv
tests/spi_mem_sva.sv
tests/spi_mem_model.sv
tests/spi_mem_tb.sv
